/* memory_island_pkg.sv */
/*
 * Memory island shared definitions
 * Sizes of the island, the direct memory protocol structs for narrow and
 * wide ports, the per-bank request struct and the wide-token state
 */

package memory_island_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------

    // Two narrow masters share the banks with one wide master
    localparam int unsigned NumNarrowPorts  = 2;
    localparam int unsigned NumBanks        = 4;

    localparam int unsigned NarrowDataWidth = 32;
    // One wide word spans one row across all banks
    localparam int unsigned WideDataWidth   = NumBanks * NarrowDataWidth;
    localparam int unsigned NarrowBeWidth   = NarrowDataWidth / 8;
    localparam int unsigned WideBeWidth     = WideDataWidth / 8;

    // Byte address layout
    // Bits 1:0 byte in word, 3:2 bank, 9:4 row, 11:10 ignored
    localparam int unsigned AddrWidth       = 12;
    localparam int unsigned WordOffWidth    = 2;
    localparam int unsigned BankSelWidth    = 2;
    localparam int unsigned RowWidth        = 6;
    localparam int unsigned BankDepth       = 64;

    // Index of a narrow port, used by round-robin and response routing
    localparam int unsigned PortIdxWidth    = (NumNarrowPorts > 1) ? $clog2(NumNarrowPorts) : 1;

    // ------------------------------------------------------------------------
    // Direct memory protocol
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic                       req;
        logic                       we;
        logic [AddrWidth-1:0]       addr;
        logic [NarrowBeWidth-1:0]   be;
        logic [NarrowDataWidth-1:0] wdata;
    } mem_narrow_req_t;

    typedef struct packed {
        logic                       gnt;
        logic                       rvalid;
        logic [NarrowDataWidth-1:0] rdata;
    } mem_narrow_rsp_t;

    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [AddrWidth-1:0]     addr;
        logic [WideBeWidth-1:0]   be;
        logic [WideDataWidth-1:0] wdata;
    } mem_wide_req_t;

    typedef struct packed {
        logic                     gnt;
        logic                     rvalid;
        logic [WideDataWidth-1:0] rdata;
    } mem_wide_rsp_t;

    // Core to bank, already arbitrated and decoded
    typedef struct packed {
        logic                       en;
        logic                       we;
        logic [RowWidth-1:0]        row;
        logic [NarrowBeWidth-1:0]   be;
        logic [NarrowDataWidth-1:0] wdata;
    } bank_req_t;

    // Wide token, tells who wins the banks when both sides request
    typedef enum logic {
        OWNER_NARROW = 1'b0,
        OWNER_WIDE   = 1'b1
    } arb_owner_e;

endpackage

/* mem_req_cut.sv */
/*
 * Port entry cut
 * One-entry spill register on the request path and one register
 * on the response path, shared by narrow and wide ports
 */

`timescale 1ns/1ps

module mem_req_cut #(
    parameter type req_t = memory_island_pkg::mem_narrow_req_t,
    parameter type rsp_t = memory_island_pkg::mem_narrow_rsp_t
) (
    input  logic clk_i,
    input  logic arst_n_i,
    // Upstream side towards the master
    input  req_t req_i,
    output rsp_t rsp_o,
    // Downstream side towards the core
    output req_t req_o,
    input  rsp_t rsp_i
);

    logic                           full_q;
    req_t                           data_q;
    logic                           accept;
    logic                           rvalid_q;
    logic [$bits(rsp_i.rdata)-1:0]  rdata_q;

    // Free slot or the held entry leaves this cycle
    assign accept = req_i.req && (!full_q || rsp_i.gnt);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
            end else if (rsp_i.gnt) begin
                full_q <= 1'b0;
            end
            rvalid_q <= rsp_i.rvalid;
        end
    end

    // Held request payload and returning read data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= req_i;
        end
        rdata_q <= rsp_i.rdata;
    end

    always_comb begin
        req_o        = data_q;
        req_o.req    = full_q;
        // Upstream grant follows the free slot
        rsp_o.gnt    = !full_q || rsp_i.gnt;
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
    end

endmodule

/* mem_bank.sv */
/*
 * Single SRAM bank
 * 64 words of 32 bits with byte enables, reads return one cycle later
 */

`timescale 1ns/1ps

module mem_bank (
    input  logic                                          clk_i,
    input  memory_island_pkg::bank_req_t                  bank_req_i,
    output logic [memory_island_pkg::NarrowDataWidth-1:0] rdata_o
);

    import memory_island_pkg::*;

    // Storage array, contents undefined after power-up
    logic [NarrowDataWidth-1:0] mem_q [BankDepth];

    always_ff @(posedge clk_i) begin
        if (bank_req_i.en) begin
            if (bank_req_i.we) begin
                // Only lanes with their enable set are touched
                for (int unsigned b = 0; b < NarrowBeWidth; b++) begin
                    if (bank_req_i.be[b]) begin
                        mem_q[bank_req_i.row][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                // Read word lands in the output register
                rdata_o <= mem_q[bank_req_i.row];
            end
        end
    end

endmodule

/* mem_bank_arbiter.sv */
/*
 * Per-bank narrow arbiter
 * Round-robin choice among the narrow ports that hit this bank,
 * blocked entirely while the wide port owns the banks
 */

`timescale 1ns/1ps

module mem_bank_arbiter (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    // One bit per narrow port that addresses this bank
    input  logic [memory_island_pkg::NumNarrowPorts-1:0] narrow_hit_i,
    // One-hot or zero
    output logic [memory_island_pkg::NumNarrowPorts-1:0] narrow_gnt_o,
    // Wide port takes all banks this cycle
    input  logic                                         wide_sel_i
);

    import memory_island_pkg::*;

    logic [PortIdxWidth-1:0] rr_q;
    logic [PortIdxWidth-1:0] rr_d;
    logic [PortIdxWidth-1:0] win_idx;
    logic                    win_vld;
    logic                    granted;

    // ------------------------------------------------------------------------
    // Winner search
    // ------------------------------------------------------------------------

    // Scan starts at the pointer and wraps around
    always_comb begin
        int unsigned idx;
        win_vld = 1'b0;
        win_idx = rr_q;
        for (int unsigned i = 0; i < NumNarrowPorts; i++) begin
            idx = (32'(rr_q) + i) % NumNarrowPorts;
            // First hit in rotated order wins
            if (!win_vld && narrow_hit_i[idx]) begin
                win_vld = 1'b1;
                win_idx = PortIdxWidth'(idx);
            end
        end
    end

    // Wide selection masks every narrow grant
    assign granted = win_vld && !wide_sel_i;

    always_comb begin
        narrow_gnt_o = '0;
        if (granted) begin
            narrow_gnt_o[win_idx] = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Pointer update
    // ------------------------------------------------------------------------

    // Next search starts just after the port that was served
    always_comb begin
        rr_d = rr_q;
        if (granted) begin
            if (32'(win_idx) == NumNarrowPorts - 1) begin
                rr_d = '0;
            end else begin
                rr_d = win_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_d;
        end
    end

endmodule

/* memory_island_core.sv */
/*
 * Memory island core
 * Decodes bank addresses, arbitrates narrow ports per bank, shares all
 * banks with the wide port by an alternating token and routes the bank
 * outputs back to the requesting ports one cycle after the access
 */

`timescale 1ns/1ps

module memory_island_core (
    input  logic                                                                clk_i,
    input  logic                                                                arst_n_i,
    input  memory_island_pkg::mem_narrow_req_t [memory_island_pkg::NumNarrowPorts-1:0] narrow_req_i,
    output memory_island_pkg::mem_narrow_rsp_t [memory_island_pkg::NumNarrowPorts-1:0] narrow_rsp_o,
    input  memory_island_pkg::mem_wide_req_t                                    wide_req_i,
    output memory_island_pkg::mem_wide_rsp_t                                    wide_rsp_o
);

    import memory_island_pkg::*;

    logic [NumBanks-1:0][NumNarrowPorts-1:0]  hit;
    logic [NumBanks-1:0][NumNarrowPorts-1:0]  narrow_gnt;
    logic [NumBanks-1:0][NarrowDataWidth-1:0] bank_rdata;
    logic [NumNarrowPorts-1:0][RowWidth-1:0]  narrow_row;
    logic [RowWidth-1:0]                      wide_row;
    logic                                     any_narrow;
    logic                                     wide_sel;
    arb_owner_e                               token_q;
    arb_owner_e                               token_d;

    // Pending access bookkeeping, one slot per bank plus the wide port
    logic [NumBanks-1:0]                      bank_busy_q;
    logic [NumBanks-1:0]                      bank_busy_d;
    logic [NumBanks-1:0][PortIdxWidth-1:0]    bank_port_q;
    logic [NumBanks-1:0][PortIdxWidth-1:0]    bank_port_d;
    logic [NumBanks-1:0]                      bank_we_q;
    logic [NumBanks-1:0]                      bank_we_d;
    logic                                     wide_pend_q;
    logic                                     wide_we_q;

    // ------------------------------------------------------------------------
    // Address decode and wide token
    // ------------------------------------------------------------------------

    always_comb begin
        hit        = '0;
        any_narrow = 1'b0;
        for (int unsigned p = 0; p < NumNarrowPorts; p++) begin
            narrow_row[p] = narrow_req_i[p].addr[WordOffWidth+BankSelWidth +: RowWidth];
            any_narrow    = any_narrow | narrow_req_i[p].req;
            hit[narrow_req_i[p].addr[WordOffWidth +: BankSelWidth]][p] = narrow_req_i[p].req;
        end
    end

    assign wide_row = wide_req_i.addr[WordOffWidth+BankSelWidth +: RowWidth];

    // Wide wins on its turn, or whenever the narrow side is idle
    assign wide_sel = wide_req_i.req && (token_q == OWNER_WIDE || !any_narrow);

    always_comb begin
        token_d = token_q;
        if (wide_sel) begin
            token_d = OWNER_NARROW;
        end else if (wide_req_i.req) begin
            // Wide port was held back, its turn comes next
            token_d = OWNER_WIDE;
        end
    end

    // ------------------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------------------

    for (genvar b = 0; b < NumBanks; b++) begin : g_bank
        bank_req_t bank_req;

        mem_bank_arbiter u_arbiter (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .narrow_hit_i (hit[b]),
            .narrow_gnt_o (narrow_gnt[b]),
            .wide_sel_i   (wide_sel)
        );

        // Wide request takes its own lane of data and byte enables
        always_comb begin
            bank_req = '0;
            if (wide_sel) begin
                bank_req.en    = 1'b1;
                bank_req.we    = wide_req_i.we;
                bank_req.row   = wide_row;
                bank_req.be    = wide_req_i.be[b*NarrowBeWidth +: NarrowBeWidth];
                bank_req.wdata = wide_req_i.wdata[b*NarrowDataWidth +: NarrowDataWidth];
            end else begin
                for (int unsigned p = 0; p < NumNarrowPorts; p++) begin
                    if (narrow_gnt[b][p]) begin
                        bank_req.en    = 1'b1;
                        bank_req.we    = narrow_req_i[p].we;
                        bank_req.row   = narrow_row[p];
                        bank_req.be    = narrow_req_i[p].be;
                        bank_req.wdata = narrow_req_i[p].wdata;
                    end
                end
            end
        end

        mem_bank u_bank (
            .clk_i      (clk_i),
            .bank_req_i (bank_req),
            .rdata_o    (bank_rdata[b])
        );
    end

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------

    // Remember which narrow port used each bank this cycle
    always_comb begin
        bank_busy_d = '0;
        bank_port_d = bank_port_q;
        bank_we_d   = bank_we_q;
        for (int unsigned b = 0; b < NumBanks; b++) begin
            for (int unsigned p = 0; p < NumNarrowPorts; p++) begin
                if (narrow_gnt[b][p]) begin
                    bank_busy_d[b] = 1'b1;
                    bank_port_d[b] = PortIdxWidth'(p);
                    bank_we_d[b]   = narrow_req_i[p].we;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bank_busy_q <= '0;
            wide_pend_q <= 1'b0;
            token_q     <= OWNER_NARROW;
        end else begin
            bank_busy_q <= bank_busy_d;
            wide_pend_q <= wide_sel;
            token_q     <= token_d;
        end
    end

    always_ff @(posedge clk_i) begin
        bank_port_q <= bank_port_d;
        bank_we_q   <= bank_we_d;
        if (wide_sel) begin
            wide_we_q <= wide_req_i.we;
        end
    end

    always_comb begin
        for (int unsigned p = 0; p < NumNarrowPorts; p++) begin
            narrow_rsp_o[p] = '0;
            for (int unsigned b = 0; b < NumBanks; b++) begin
                narrow_rsp_o[p].gnt = narrow_rsp_o[p].gnt | narrow_gnt[b][p];
                if (bank_busy_q[b] && bank_port_q[b] == PortIdxWidth'(p)) begin
                    narrow_rsp_o[p].rvalid = 1'b1;
                    // Writes answer with zero data
                    narrow_rsp_o[p].rdata  = bank_we_q[b] ? '0 : bank_rdata[b];
                end
            end
        end
    end

    // Wide read gathers all four lanes, bank 0 in the low word
    always_comb begin
        wide_rsp_o.gnt    = wide_sel;
        wide_rsp_o.rvalid = wide_pend_q;
        wide_rsp_o.rdata  = (wide_pend_q && !wide_we_q) ? bank_rdata : '0;
    end

endmodule

/* memory_island_wrap.sv */
/*
 * Memory island top level
 * Puts an entry cut on each narrow port and on the wide port and
 * hands all of them to the island core
 */

`timescale 1ns/1ps

module memory_island_wrap (
    input  logic                                                                clk_i,
    input  logic                                                                arst_n_i,
    input  memory_island_pkg::mem_narrow_req_t [memory_island_pkg::NumNarrowPorts-1:0] narrow_req_i,
    output memory_island_pkg::mem_narrow_rsp_t [memory_island_pkg::NumNarrowPorts-1:0] narrow_rsp_o,
    input  memory_island_pkg::mem_wide_req_t                                    wide_req_i,
    output memory_island_pkg::mem_wide_rsp_t                                    wide_rsp_o
);

    import memory_island_pkg::*;

    // Cut outputs towards the core
    mem_narrow_req_t [NumNarrowPorts-1:0] narrow_req_cut;
    mem_narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp_core;
    mem_wide_req_t                        wide_req_cut;
    mem_wide_rsp_t                        wide_rsp_core;

    // ------------------------------------------------------------------------
    // Entry cuts
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NumNarrowPorts; i++) begin : g_narrow_cut
        mem_req_cut #(
            .req_t (mem_narrow_req_t),
            .rsp_t (mem_narrow_rsp_t)
        ) u_cut (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (narrow_req_i[i]),
            .rsp_o    (narrow_rsp_o[i]),
            .req_o    (narrow_req_cut[i]),
            .rsp_i    (narrow_rsp_core[i])
        );
    end

    mem_req_cut #(
        .req_t (mem_wide_req_t),
        .rsp_t (mem_wide_rsp_t)
    ) u_wide_cut (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (wide_req_i),
        .rsp_o    (wide_rsp_o),
        .req_o    (wide_req_cut),
        .rsp_i    (wide_rsp_core)
    );

    // Core sees only registered requests
    memory_island_core u_core (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .narrow_req_i (narrow_req_cut),
        .narrow_rsp_o (narrow_rsp_core),
        .wide_req_i   (wide_req_cut),
        .wide_rsp_o   (wide_rsp_core)
    );

endmodule

/* tb_memory_island.sv */
/*
 * Memory island testbench
 * Runs a table of narrow and wide requests through the island, checks each
 * response against a reference word array and measures the idle latency
 */

`timescale 1ns/1ps

module tb_memory_island;

    import memory_island_pkg::*;

    localparam int unsigned GntTimeout  = 50;
    localparam int unsigned IdleTimeout = 50;
    localparam logic [31:0] LfsrTaps    = 32'h8020_0003;
    // Port codes of the table, wide port last
    localparam logic [1:0]  P0 = 2'd0;
    localparam logic [1:0]  P1 = 2'd1;
    localparam logic [1:0]  PW = 2'd2;
    localparam logic        WR = 1'b1;
    localparam logic        RD = 1'b0;

    typedef struct packed {
        logic [1:0]   port;
        logic         we;
        logic [11:0]  addr;
        logic [15:0]  be;
        logic [127:0] wdata;
        // Launch together with the next entry
        logic         with_next;
    } stim_t;

    logic                                 clk;
    logic                                 arst_n;
    mem_narrow_req_t [NumNarrowPorts-1:0] narrow_req;
    mem_narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp;
    mem_wide_req_t                        wide_req;
    mem_wide_rsp_t                        wide_rsp;

    stim_t        stim_tbl [$];
    // Reference words, index is address bits 9:2 which is {row, bank}
    logic [31:0]  ref_mem [256];
    // Expected responses per port, wide port at index 2
    logic [127:0] exp_q [3][$];
    int unsigned  gnt_cyc [3];
    int unsigned  rsp_cyc [3];
    int unsigned  cyc = 0;
    logic [31:0]  lfsr_q;

    memory_island_wrap uut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp)
    );

    always #20 clk = ~clk;

    // Cycle count, read at the falling edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] want);
        if (got !== want) begin
            fail_run($sformatf("** Error: %s got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    // Galois LFSR, output is the bit shifted out
    function automatic logic lfsr_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = b ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);
        return b;
    endfunction

    function automatic logic [127:0] rand_data(input int unsigned nbits);
        logic [127:0] d;
        d = '0;
        for (int unsigned i = 0; i < nbits; i++) begin
            d[i] = lfsr_bit();
        end
        return d;
    endfunction

    function automatic stim_t entry(input logic [1:0] port, input logic we,
                                    input logic [11:0] addr, input logic [15:0] be,
                                    input logic [127:0] wdata, input logic rnd,
                                    input logic with_next);
        stim_t s;
        s.port      = port;
        s.we        = we;
        s.addr      = addr;
        s.be        = be;
        s.with_next = with_next;
        // Random data is drawn in table order
        s.wdata     = !rnd ? wdata : rand_data((port == PW) ? 128 : 32);
        return s;
    endfunction

    function automatic void write_word(input logic [7:0] w, input logic [3:0] be,
                                       input logic [31:0] data);
        for (int unsigned b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[w][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Model side of a granted request, returns the expected rdata
    function automatic logic [127:0] model_access(input stim_t s);
        logic [127:0] want;
        logic [7:0]   w;
        want = '0;
        if (s.port == PW) begin
            // Same row in all banks, bank k in lane k
            for (int unsigned k = 0; k < 4; k++) begin
                w = {s.addr[9:4], k[1:0]};
                if (s.we) begin
                    write_word(w, s.be[4*k +: 4], s.wdata[32*k +: 32]);
                end else begin
                    want[32*k +: 32] = ref_mem[w];
                end
            end
        end else begin
            w = s.addr[9:2];
            if (s.we) begin
                write_word(w, s.be[3:0], s.wdata[31:0]);
            end else begin
                want[31:0] = ref_mem[w];
            end
        end
        return want;
    endfunction

    function automatic logic port_gnt(input logic [1:0] p);
        return (p == PW) ? wide_rsp.gnt : narrow_rsp[p[0]].gnt;
    endfunction

    // ------------------------------------------------------------------------
    // Driving
    // ------------------------------------------------------------------------

    task automatic issue(input stim_t s);
        int unsigned waited;
        waited = 0;
        if (s.port == PW) begin
            wide_req.req   = 1'b1;
            wide_req.we    = s.we;
            wide_req.addr  = s.addr;
            wide_req.be    = s.be;
            wide_req.wdata = s.wdata;
        end else begin
            narrow_req[s.port[0]].req   = 1'b1;
            narrow_req[s.port[0]].we    = s.we;
            narrow_req[s.port[0]].addr  = s.addr;
            narrow_req[s.port[0]].be    = s.be[3:0];
            narrow_req[s.port[0]].wdata = s.wdata[31:0];
        end
        @(negedge clk);
        while (!port_gnt(s.port)) begin
            waited++;
            if (waited >= GntTimeout) begin
                fail_run($sformatf("Port %0d request to 0x%0h was never granted",
                                   s.port, s.addr));
            end
            @(negedge clk);
        end
        gnt_cyc[s.port] = cyc;
        exp_q[s.port].push_back(model_access(s));
        // Transfer happens at this edge
        @(posedge clk);
        #2;
    endtask

    task automatic release_req(input logic [1:0] p);
        if (p == PW) begin
            wide_req.req = 1'b0;
        end else begin
            narrow_req[p[0]].req = 1'b0;
        end
    endtask

    // Back-to-back requests of one port within a group
    task automatic run_port(input logic [1:0] p, input int first, input int last);
        for (int k = first; k <= last; k++) begin
            if (stim_tbl[k].port == p) begin
                issue(stim_tbl[k]);
            end
        end
        release_req(p);
    endtask

    task automatic wait_idle();
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
            waited++;
            if (waited >= IdleTimeout) begin
                fail_run("Responses still missing after the idle timeout");
            end
            @(posedge clk);
        end
        #2;
    endtask

    // ------------------------------------------------------------------------
    // Response monitor
    // ------------------------------------------------------------------------

    task automatic take_rsp(input logic [1:0] p, input logic [127:0] got, input string name);
        logic [127:0] want;
        if (exp_q[p].size() == 0) begin
            fail_run($sformatf("Response on %s with no request outstanding", name));
        end else begin
            want = exp_q[p].pop_front();
            check(name, got, want);
            rsp_cyc[p] = cyc;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < NumNarrowPorts; p++) begin
                if (narrow_rsp[p].rvalid) begin
                    take_rsp(2'(p), 128'(narrow_rsp[p].rdata),
                             $sformatf("narrow_rsp[%0d].rdata", p));
                end
            end
            if (wide_rsp.rvalid) begin
                take_rsp(PW, wide_rsp.rdata, "wide_rsp.rdata");
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic load_table();
        // Narrow write and read back with partial byte enables
        stim_tbl.push_back(entry(P0, WR, 12'h010, 16'h000f, 128'h1122_3344, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P0, RD, 12'h010, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P0, WR, 12'h010, 16'h0005, 128'haabb_ccdd, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P0, RD, 12'h010, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P1, WR, 12'h024, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P1, WR, 12'h024, 16'h000a, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P1, RD, 12'h024, 16'h000f, '0, 1'b0, 1'b0));
        // Wide write seen through narrow reads
        stim_tbl.push_back(entry(PW, WR, 12'h100, 16'hffff, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P0, RD, 12'h100, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P1, RD, 12'h104, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P0, RD, 12'h108, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P1, RD, 12'h10c, 16'h000f, '0, 1'b0, 1'b0));
        // Narrow writes gathered by a wide read, then a partial wide write
        stim_tbl.push_back(entry(P0, WR, 12'h200, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P1, WR, 12'h204, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P0, WR, 12'h208, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P1, WR, 12'h20c, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(PW, RD, 12'h200, 16'hffff, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(PW, WR, 12'h200, 16'h0f0f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(PW, RD, 12'h200, 16'hffff, '0, 1'b0, 1'b0));
        // Simultaneous narrow requests, different banks then the same bank
        stim_tbl.push_back(entry(P0, RD, 12'h010, 16'h000f, '0, 1'b0, 1'b1));
        stim_tbl.push_back(entry(P1, RD, 12'h024, 16'h000f, '0, 1'b0, 1'b0));
        stim_tbl.push_back(entry(P0, WR, 12'h030, 16'h000f, '0, 1'b1, 1'b1));
        stim_tbl.push_back(entry(P1, WR, 12'h070, 16'h000f, '0, 1'b1, 1'b0));
        stim_tbl.push_back(entry(P0, RD, 12'h070, 16'h000f, '0, 1'b0, 1'b1));
        stim_tbl.push_back(entry(P1, RD, 12'h030, 16'h000f, '0, 1'b0, 1'b0));
        // Wide read under back-to-back narrow traffic
        stim_tbl.push_back(entry(P0, WR, 12'h040, 16'h000f, '0, 1'b1, 1'b1));
        stim_tbl.push_back(entry(P0, WR, 12'h044, 16'h000f, '0, 1'b1, 1'b1));
        stim_tbl.push_back(entry(P1, WR, 12'h048, 16'h000f, '0, 1'b1, 1'b1));
        stim_tbl.push_back(entry(P1, WR, 12'h04c, 16'h000f, '0, 1'b1, 1'b1));
        stim_tbl.push_back(entry(PW, RD, 12'h100, 16'hffff, '0, 1'b0, 1'b1));
        stim_tbl.push_back(entry(P0, RD, 12'h040, 16'h000f, '0, 1'b0, 1'b1));
        stim_tbl.push_back(entry(P1, RD, 12'h048, 16'h000f, '0, 1'b0, 1'b0));
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int first;
        int last;
        clk        = 1'b0;
        arst_n     = 1'b0;
        narrow_req = '0;
        wide_req   = '0;
        lfsr_q     = 32'hc7a9;
        load_table();
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Empty cuts grant, nothing in flight
        @(negedge clk);
        check("narrow_rsp[0].gnt", 128'(narrow_rsp[0].gnt), 128'd1);
        check("narrow_rsp[1].gnt", 128'(narrow_rsp[1].gnt), 128'd1);
        check("wide_rsp.gnt", 128'(wide_rsp.gnt), 128'd1);
        check("narrow_rsp[0].rvalid", 128'(narrow_rsp[0].rvalid), 128'd0);
        check("narrow_rsp[1].rvalid", 128'(narrow_rsp[1].rvalid), 128'd0);
        check("wide_rsp.rvalid", 128'(wide_rsp.rvalid), 128'd0);
        @(posedge clk);
        #2;

        // Each group of linked entries starts in one cycle
        first = 0;
        while (first < stim_tbl.size()) begin
            last = first;
            while (stim_tbl[last].with_next && last + 1 < stim_tbl.size()) begin
                last++;
            end
            fork
                run_port(P0, first, last);
                run_port(P1, first, last);
                run_port(PW, first, last);
            join
            wait_idle();
            first = last + 1;
        end

        // Idle island, grant to rvalid is cut plus bank plus response cut
        issue(entry(P0, RD, 12'h010, 16'h000f, '0, 1'b0, 1'b0));
        release_req(P0);
        wait_idle();
        check("narrow_rsp[0] latency", 128'(rsp_cyc[0] - gnt_cyc[0]), 128'd3);

        $display("Test OK");
        $finish;
    end

endmodule

/* list.f */
memory_island_pkg.sv
mem_req_cut.sv
mem_bank.sv
mem_bank_arbiter.sv
memory_island_core.sv
memory_island_wrap.sv
tb_memory_island.sv

/* run.sh */
#!/bin/sh
# Build the memory island testbench with Verilator and run it
# The exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_memory_island -f list.f &&
./obj_dir/Vtb_memory_island ||
{ echo "simulation did not pass"; exit 1; }
